/* src/crc_macros.svh */
// crc macros: width, polynomial, start value and bit order of the ethernet fcs
`ifndef CRC_MACROS_SVH
`define CRC_MACROS_SVH

// lfsr / crc register width
`define CRC_W 32
// crc-32 polynomial, x^32 term implied by the width
`define CRC_POLY 32'h04c11db7
// state after reset and at each frame start
`define CRC_INIT 32'hffffffff
// bits shifted per step, one byte
`define CRC_DATA_W 8
// byte counter width, wraps at 2^16
`define CRC_CNT_W 16

// reflected order: data lsb first, state bit-reversed on output
`define CRC_REVERSE 1
// final xor with all ones
`define CRC_INVERT 1

`endif

/* src/crc_pkg.sv */
// crc package: types for the crc result word and the lfsr state
`include "crc_macros.svh"

package crc_pkg;

    // crc result as seen outside
    // bit order already reflected, ready for the fcs field
    typedef logic [`CRC_W-1:0] crc_word_t;

    // internal galois state
    // same width as the result, kept in msb-first order
    typedef crc_word_t lfsr_state_t;

endpackage

/* src/frame_pkg.sv */
// frame package: types for frame payload bytes and per-frame byte counts
`include "crc_macros.svh"

package frame_pkg;

    // one payload byte per beat
    typedef logic [`CRC_DATA_W-1:0] data_byte_t;

    // bytes seen in one frame
    // modulo 2^16, so long frames wrap
    typedef logic [`CRC_CNT_W-1:0] byte_count_t;

endpackage

/* src/lfsr_step.sv */
// lfsr step: unrolled galois lfsr that advances the crc state over one data byte
`timescale 1ns/100ps
`include "crc_macros.svh"

module lfsr_step
    import crc_pkg::*, frame_pkg::*;
(
    input  data_byte_t data_in,
    input  crc_word_t  state_in,
    output crc_word_t  state_out
);

    // feedback taps
    localparam crc_word_t POLY = `CRC_POLY;
    // shifts per step
    localparam int DW = `CRC_DATA_W;
    // register width
    localparam int W = `CRC_W;

    // state after each single-bit shift
    // stage 0 is the incoming state, stage DW the result
    crc_word_t stage [DW+1];

    assign stage[0] = state_in;

    // one shift per data bit, unrolled at elaboration
    for (genvar i = 0; i < DW; i++) begin : g_shift
        // data bit for this shift
        // lsb first for the reflected crc, msb first otherwise
        localparam int SEL = (`CRC_REVERSE != 0) ? i : DW - 1 - i;

        logic fb;

        // feedback is the outgoing msb mixed with the data bit
        assign fb = stage[i][W-1] ^ data_in[SEL];

        // galois form: shift up, xor taps in when feedback is set
        // x^0 tap brings fb into bit 0 through the polynomial lsb
        assign stage[i+1] = {stage[i][W-2:0], 1'b0} ^ (fb ? POLY : '0);
    end

    // state after the whole byte
    assign state_out = stage[DW];

endmodule

/* src/lfsr_crc.sv */
// lfsr crc: crc state register over lfsr_step, with restart and reflected output
`timescale 1ns/100ps
`include "crc_macros.svh"

module lfsr_crc
    import crc_pkg::*, frame_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  data_byte_t data_in,
    input  logic       data_in_valid,
    output crc_word_t  crc_out
);

    lfsr_state_t state_reg;
    crc_word_t   next_state;
    crc_word_t   state_rev;

    // next state over the current byte
    lfsr_step u_step (
        .data_in   (data_in),
        .state_in  (state_reg),
        .state_out (next_state)
    );

    // rst also acts as the frame restart
    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= `CRC_INIT;
        end else if (data_in_valid) begin
            state_reg <= next_state;
        end
    end

    // reflect state into fcs bit order
    always_comb begin
        for (int i = 0; i < `CRC_W; i++) begin
            state_rev[i] = (`CRC_REVERSE != 0) ? state_reg[`CRC_W-1-i] : state_reg[i];
        end
    end

    // final inversion
    assign crc_out = (`CRC_INVERT != 0) ? ~state_rev : state_rev;

    // an x on a shifted byte would poison every later state of the frame
    a_data_known: assert property (
        @(posedge clk) disable iff (rst) data_in_valid |-> !$isunknown(data_in)
    ) else $error("lfsr_crc: unknown data byte while valid");

endmodule

/* src/byte_receiver.sv */
// byte receiver: four-phase req/ack sink that turns each byte into a one-cycle beat
`timescale 1ns/100ps

module byte_receiver
    import frame_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_req,
    input  logic       in_last,
    input  logic       beat_ready,
    input  data_byte_t in_data,
    output logic       in_ack,
    output logic       beat_valid,
    output logic       beat_last,
    output data_byte_t beat_data
);

    typedef enum logic {
        ST_IDLE,
        ST_ACKED
    } rx_state_t;

    rx_state_t state;
    logic      last_reg;

    // handshake and beat strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            beat_valid <= 1'b0;
        end else begin
            // strobe lasts one cycle
            beat_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // new request, accepted only when processing allows it
                    if (in_req && beat_ready) begin
                        state      <= ST_ACKED;
                        beat_valid <= 1'b1;
                    end
                end
                ST_ACKED: begin
                    // release ack once the requester has let go
                    if (!in_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload, loaded with the accepted byte
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && in_req && beat_ready) begin
            beat_data <= in_data;
            last_reg  <= in_last;
        end
    end

    assign in_ack = (state == ST_ACKED);

    // while idle, show the pending last flag so a frame end can be stalled
    // otherwise the captured flag that goes with the beat
    assign beat_last = (state == ST_IDLE) ? in_last : last_reg;

    // ack may only drop after req has dropped
    a_ack_hold: assert property (
        @(posedge clk) disable iff (rst) (in_ack && in_req) |=> in_ack
    ) else $error("byte_receiver: in_ack fell while in_req high");

endmodule

/* src/crc_frame_ctrl.sv */
// frame controller: runs the crc over beats, counts bytes, emits one result per frame
`timescale 1ns/100ps

module crc_frame_ctrl
    import crc_pkg::*, frame_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        beat_valid,
    input  logic        beat_last,
    input  logic        sender_free,
    input  data_byte_t  beat_data,
    output logic        beat_ready,
    output logic        result_valid,
    output crc_word_t   result_crc,
    output byte_count_t result_count
);

    // high the cycle after a last beat, crc_out is final then
    logic        frame_end;
    logic        crc_clear;
    crc_word_t   crc_out;
    byte_count_t byte_cnt;

    // restart on reset and at every frame end
    assign crc_clear = rst || frame_end;

    lfsr_crc u_crc (
        .clk           (clk),
        .rst           (crc_clear),
        .data_in       (beat_data),
        .data_in_valid (beat_valid),
        .crc_out       (crc_out)
    );

    // bytes of the current frame, last byte included
    always_ff @(posedge clk) begin
        if (crc_clear) begin
            byte_cnt <= '0;
        end else if (beat_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // frame end marker and result strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_end    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            frame_end    <= beat_valid && beat_last;
            result_valid <= frame_end;
        end
    end

    // result payload, taken at the restart edge
    always_ff @(posedge clk) begin
        if (frame_end) begin
            result_crc   <= crc_out;
            result_count <= byte_cnt;
        end
    end

    // a last byte waits while a result is in flight or the sender is busy
    // ordinary bytes always pass
    assign beat_ready = !(beat_last && (!sender_free || frame_end || result_valid));

    // the sender holds one result, a second would be lost
    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst) result_valid |-> sender_free
    ) else $error("crc_frame_ctrl: result_valid while sender busy");

endmodule

/* src/fcs_sender.sv */
// fcs sender: four-phase req/ack source presenting one frame's crc and byte count
`timescale 1ns/100ps

module fcs_sender
    import crc_pkg::*, frame_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        result_valid,
    input  logic        fcs_ack,
    input  crc_word_t   result_crc,
    input  byte_count_t result_count,
    output logic        fcs_req,
    output logic        sender_free,
    output crc_word_t   fcs_crc,
    output byte_count_t fcs_count
);

    typedef enum logic [1:0] {
        ST_FREE,
        ST_REQ,
        ST_WAIT_LOW
    } tx_state_t;

    tx_state_t state;

    // four-phase source
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_FREE;
        end else begin
            case (state)
                ST_FREE: begin
                    if (result_valid) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // consumer took it, drop req
                    if (fcs_ack) begin
                        state <= ST_WAIT_LOW;
                    end
                end
                ST_WAIT_LOW: begin
                    // ack back low, ready for the next frame
                    if (!fcs_ack) begin
                        state <= ST_FREE;
                    end
                end
                default: state <= ST_FREE;
            endcase
        end
    end

    // result held until the handshake completes
    always_ff @(posedge clk) begin
        if (state == ST_FREE && result_valid) begin
            fcs_crc   <= result_crc;
            fcs_count <= result_count;
        end
    end

    assign fcs_req     = (state == ST_REQ);
    assign sender_free = (state == ST_FREE);

    // payload must not move under a raised request
    a_crc_stable: assert property (
        @(posedge clk) disable iff (rst) fcs_req |=> (!fcs_req || $stable(fcs_crc))
    ) else $error("fcs_sender: fcs_crc changed while fcs_req high");

endmodule

/* src/crc_top.sv */
// crc top: byte receiver, frame controller and fcs sender for the ethernet fcs path
`timescale 1ns/100ps

module crc_top
    import crc_pkg::*, frame_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_req,
    input  logic        in_last,
    input  logic        fcs_ack,
    input  data_byte_t  in_data,
    output logic        in_ack,
    output logic        fcs_req,
    output crc_word_t   fcs_crc,
    output byte_count_t fcs_count
);

    // beat path, receiver to controller
    logic        beat_valid;
    logic        beat_last;
    logic        beat_ready;
    data_byte_t  beat_data;

    // result path, controller to sender
    logic        result_valid;
    logic        sender_free;
    crc_word_t   result_crc;
    byte_count_t result_count;

    byte_receiver u_rx (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_last    (in_last),
        .beat_ready (beat_ready),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .beat_valid (beat_valid),
        .beat_last  (beat_last),
        .beat_data  (beat_data)
    );

    crc_frame_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .beat_valid   (beat_valid),
        .beat_last    (beat_last),
        .sender_free  (sender_free),
        .beat_data    (beat_data),
        .beat_ready   (beat_ready),
        .result_valid (result_valid),
        .result_crc   (result_crc),
        .result_count (result_count)
    );

    fcs_sender u_tx (
        .clk          (clk),
        .rst          (rst),
        .result_valid (result_valid),
        .fcs_ack      (fcs_ack),
        .result_crc   (result_crc),
        .result_count (result_count),
        .fcs_req      (fcs_req),
        .sender_free  (sender_free),
        .fcs_crc      (fcs_crc),
        .fcs_count    (fcs_count)
    );

endmodule

/* verif/crc_tb.sv */
// crc testbench: directed tests of the ethernet fcs path against a bitwise crc-32 model
`timescale 1ns/100ps

module crc_tb
    import crc_pkg::*, frame_pkg::*;
();

    // cycles any single wait may take
    localparam int TIMEOUT = 200;

    logic        clk;
    logic        rst;
    logic        in_req;
    logic        in_last;
    logic        fcs_ack;
    data_byte_t  in_data;
    logic        in_ack;
    logic        fcs_req;
    crc_word_t   fcs_crc;
    byte_count_t fcs_count;

    int value_errors;
    int proto_errors;
    int timeouts;

    // frame under test and results still owed by the DUT
    data_byte_t  frame_q[$];
    crc_word_t   exp_crc_q[$];
    byte_count_t exp_cnt_q[$];

    // samples from the previous rising edge
    logic      prev_in_req;
    logic      prev_in_ack;
    logic      prev_fcs_req;
    logic      prev_fcs_ack;
    crc_word_t prev_fcs_crc;

    crc_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_req    (in_req),
        .in_last   (in_last),
        .fcs_ack   (fcs_ack),
        .in_data   (in_data),
        .in_ack    (in_ack),
        .fcs_req   (fcs_req),
        .fcs_crc   (fcs_crc),
        .fcs_count (fcs_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // handshake order on both links
    always @(posedge clk) begin
        if (!rst) begin
            if (in_ack && !prev_in_ack && !prev_in_req) begin
                proto_errors++;
                $display("protocol error: in_ack rose without in_req at %0t", $time);
            end
            if (!in_ack && prev_in_ack && prev_in_req) begin
                proto_errors++;
                $display("protocol error: in_ack fell while in_req high at %0t", $time);
            end
            if (!fcs_req && prev_fcs_req && !prev_fcs_ack) begin
                proto_errors++;
                $display("protocol error: fcs_req fell before fcs_ack at %0t", $time);
            end
            if (fcs_req && prev_fcs_req && fcs_crc !== prev_fcs_crc) begin
                proto_errors++;
                $display("protocol error: fcs_crc moved under fcs_req at %0t", $time);
            end
        end
        prev_in_req  = in_req;
        prev_in_ack  = in_ack;
        prev_fcs_req = fcs_req;
        prev_fcs_ack = fcs_ack;
        prev_fcs_crc = fcs_crc;
    end

    task automatic check_crc(input string name, input crc_word_t got, input crc_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input byte_count_t got,
                               input byte_count_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    // reflected crc-32, one bit at a time
    function automatic crc_word_t model_crc();
        crc_word_t c;
        c = 32'hffffffff;
        foreach (frame_q[i]) begin
            c = c ^ crc_word_t'(frame_q[i]);
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic wait_in_ack(input logic level);
        int n;
        n = 0;
        while (in_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (in_ack !== level) begin
            timeouts++;
            $display("timeout: in_ack did not go to %0b within %0d cycles", level, TIMEOUT);
        end
    endtask

    task automatic wait_fcs_req(input logic level);
        int n;
        n = 0;
        while (fcs_req !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (fcs_req !== level) begin
            timeouts++;
            $display("timeout: fcs_req did not go to %0b within %0d cycles", level, TIMEOUT);
        end
    endtask

    // one full four-phase transfer on the input link
    task automatic send_byte(input data_byte_t d, input logic last);
        @(negedge clk);
        in_data = d;
        in_last = last;
        in_req  = 1'b1;
        wait_in_ack(1'b1);
        in_req = 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic fill_random(input int len);
        frame_q.delete();
        repeat (len) frame_q.push_back(data_byte_t'($urandom));
    endtask

    // model result for the current frame, count wraps like the DUT
    task automatic expect_frame();
        exp_crc_q.push_back(model_crc());
        exp_cnt_q.push_back(byte_count_t'(frame_q.size()));
    endtask

    task automatic send_frame();
        expect_frame();
        foreach (frame_q[i]) begin
            send_byte(frame_q[i], i == frame_q.size() - 1);
        end
    endtask

    // take one result off the output link and check it in order
    task automatic recv_result(output crc_word_t got);
        crc_word_t   exp_crc;
        byte_count_t exp_cnt;
        wait_fcs_req(1'b1);
        got = fcs_crc;
        if (exp_crc_q.size() == 0) begin
            value_errors++;
            $display("result arrived with no frame outstanding");
        end else begin
            exp_crc = exp_crc_q.pop_front();
            exp_cnt = exp_cnt_q.pop_front();
            check_crc("fcs_crc", fcs_crc, exp_crc);
            check_count("fcs_count", fcs_count, exp_cnt);
        end
        fcs_ack = 1'b1;
        wait_fcs_req(1'b0);
        fcs_ack = 1'b0;
    endtask

    task automatic test_reset();
        check_level("in_ack", in_ack, 1'b0);
        check_level("fcs_req", fcs_req, 1'b0);
    endtask

    // ascii "123456789", the usual crc-32 check value
    task automatic test_check_value();
        crc_word_t got;
        frame_q.delete();
        for (int i = 0; i < 9; i++) begin
            frame_q.push_back(data_byte_t'(8'h31 + i));
        end
        check_crc("model crc", model_crc(), 32'hcbf43926);
        send_frame();
        recv_result(got);
        check_crc("fcs_crc check value", got, 32'hcbf43926);
    endtask

    task automatic test_random_frames();
        crc_word_t got;
        fill_random(1);
        send_frame();
        recv_result(got);
        repeat (10) begin
            fill_random($urandom_range(64, 1));
            send_frame();
            recv_result(got);
        end
    endtask

    // second frame runs while the first result sits unclaimed
    task automatic test_back_pressure();
        crc_word_t got;
        fill_random(5);
        send_frame();
        wait_fcs_req(1'b1);
        fill_random(12);
        expect_frame();
        for (int i = 0; i < frame_q.size() - 1; i++) begin
            send_byte(frame_q[i], 1'b0);
        end
        // last byte must stall
        @(negedge clk);
        in_data = frame_q[frame_q.size() - 1];
        in_last = 1'b1;
        in_req  = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (in_ack) begin
                proto_errors++;
                $display("last byte was acknowledged while the first result was pending");
            end
        end
        recv_result(got);
        wait_in_ack(1'b1);
        in_req = 1'b0;
        wait_in_ack(1'b0);
        recv_result(got);
    endtask

    // same frame twice with no gap, crc must restart in between
    task automatic test_back_to_back();
        crc_word_t first;
        crc_word_t second;
        fill_random(20);
        fork
            begin
                send_frame();
                send_frame();
            end
            begin
                recv_result(first);
                recv_result(second);
            end
        join
        check_crc("fcs_crc repeat", second, first);
    endtask

    initial begin
        void'($urandom(39812));
        rst          = 1'b1;
        in_req       = 1'b0;
        in_last      = 1'b0;
        in_data      = '0;
        fcs_ack      = 1'b0;
        value_errors = 0;
        proto_errors = 0;
        timeouts     = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        test_reset();
        test_check_value();
        test_random_frames();
        test_back_pressure();
        test_back_to_back();

        repeat (5) @(negedge clk);
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, proto_errors, timeouts);
        if (value_errors + proto_errors + timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
src/crc_pkg.sv
src/frame_pkg.sv
src/lfsr_step.sv
src/lfsr_crc.sv
src/byte_receiver.sv
src/crc_frame_ctrl.sv
src/fcs_sender.sv
src/crc_top.sv
verif/crc_tb.sv

/* Makefile */
# Verilator build and run of the crc testbench

SRCS := $(shell grep '\.sv$$' verilog.f) src/crc_macros.svh

.PHONY: run clean

run: obj_dir/Vcrc_tb
	./obj_dir/Vcrc_tb | tee sim.log
	grep -q "Test OK" sim.log

obj_dir/Vcrc_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module crc_tb

clean:
	rm -rf obj_dir sim.log
